// ==== Makefile ====
TOP = icache_tb

.PHONY: help test clean

help:
	@echo "make test   build with Verilator and run the testbench"
	@echo "make clean  remove the build directory"
	@echo "make help   list these targets"

test:
	verilator --binary --timing -j 0 --top-module $(TOP) -f icache.f -Mdir obj_dir
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "TEST PASS"

clean:
	rm -rf obj_dir

// ==== dv/icache_stimulus.txt ====
# name  fetch_addr  expected_word  expected_requests_so_far
# word at address A is A xor 5a5a0000, addresses and words in hex
miss_first 00000040 5a5a0040 1
hit_line 00000044 5a5a0044 1
hit_line 0000007c 5a5a007c 1
hit_burst 00000048 5a5a0048 1
hit_burst 0000004c 5a5a004c 1
hit_burst 00000050 5a5a0050 1
hit_burst 00000060 5a5a0060 1
miss_second 00000080 5a5a0080 2
hit_burst 00000084 5a5a0084 2
hit_burst 000000bc 5a5a00bc 2
hit_burst 00000040 5a5a0040 2
hit_burst 00000070 5a5a0070 2
uncached 10000040 4a5a0040 3
uncached_repeat 10000040 4a5a0040 4
uncached 1000a5c4 4a5aa5c4 5
hit_after_uncached 00000058 5a5a0058 5
evict_a 00000100 5a5a0100 6
evict_b 00002100 5a5a2100 7
evict_a 00000104 5a5a0104 8
evict_b 0000213c 5a5a213c 9
evict_a 00000100 5a5a0100 10
refill_far 80001fc0 da5a1fc0 11
hit_far 80001ffc da5a1ffc 11
refill_far 23456788 791f6788 12
hit_far 234567bc 791f67bc 12
refill_mid 00000e74 5a5a0e74 13
hit_burst 00000e40 5a5a0e40 13
hit_burst 00000e7c 5a5a0e7c 13
hit_burst 00000080 5a5a0080 13

// ==== dv/icache_tb.sv ====
`timescale 1ns/1ps

module icache_tb import icache_pkg::*, mem_bus_pkg::*; ();

  logic              clk;
  logic              rst;
  logic              fetch_valid_i;
  logic [ADDR_W-1:0] fetch_addr_i;
  logic              fetch_rvalid_o;
  logic [DATA_W-1:0] fetch_rdata_o;
  logic              mem_req_valid_o;
  mem_req_t          mem_req_o;
  logic              mem_rvalid_i;
  logic [DATA_W-1:0] mem_rdata_i;

  // stimulus table, one entry per file line
  string       name_q[$];
  logic [31:0] addr_q[$];
  logic [31:0] word_q[$];
  int          count_q[$];
  bit          loaded = 1'b0;

  // address the fetch side is working on, for request rule checks
  logic [31:0] cur_addr;
  int req_count = 0;
  int mismatch_errors = 0;
  int protocol_errors = 0;
  int timeout_errors = 0;

  icache_top u_icache_top (
    .clk             (clk),
    .rst             (rst),
    .fetch_valid_i   (fetch_valid_i),
    .fetch_addr_i    (fetch_addr_i),
    .fetch_rvalid_o  (fetch_rvalid_o),
    .fetch_rdata_o   (fetch_rdata_o),
    .mem_req_valid_o (mem_req_valid_o),
    .mem_req_o       (mem_req_o),
    .mem_rvalid_i    (mem_rvalid_i),
    .mem_rdata_i     (mem_rdata_i)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // memory contents, a pattern over the whole address
  function automatic logic [31:0] mem_word(input logic [31:0] a);
    return a ^ 32'h5a5a_0000;
  endfunction

  task automatic check_value(input string what, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (expected !== actual) begin
      $display("MISMATCH %s expected %h actual %h", what, expected, actual);
      mismatch_errors++;
    end
  endtask

  // line refill for cacheable space, single word for the uncached region
  task automatic check_request(input mem_req_t req);
    logic [31:0] want_addr;
    logic [7:0] want_len;
    if (cur_addr[31:28] == UNCACHED_REGION_MSB) begin
      want_addr = {cur_addr[31:2], 2'b00};
      want_len = BURST_LEN_SINGLE;
    end else begin
      want_addr = {cur_addr[31:OFFSET_W], {OFFSET_W{1'b0}}};
      want_len = BURST_LEN_LINE;
    end
    if (req.addr !== want_addr || req.len !== want_len || req.size !== SIZE_WORD) begin
      $display("memory request addr %h len %0d size %h is wrong for fetch %h",
               req.addr, req.len, req.size, cur_addr);
      protocol_errors++;
    end
  endtask

  task automatic load_stimulus();
    int fd;
    string tag;
    string rest;
    logic [31:0] a;
    logic [31:0] w;
    int c;
    fd = $fopen("dv/icache_stimulus.txt", "r");
    if (fd == 0) begin
      $display("could not open dv/icache_stimulus.txt");
      protocol_errors++;
    end else begin
      while ($fscanf(fd, "%s", tag) == 1) begin
        if (tag.substr(0, 0) == "#") begin
          void'($fgets(rest, fd));
        end else if ($fscanf(fd, "%h %h %d", a, w, c) == 3) begin
          name_q.push_back(tag);
          addr_q.push_back(a);
          word_q.push_back(w);
          count_q.push_back(c);
        end else begin
          $display("stimulus line for %s could not be parsed", tag);
          protocol_errors++;
        end
      end
      $fclose(fd);
    end
    loaded = 1'b1;
  endtask

  // wait out the repeated hit from the re-captured address
  task automatic drain_responses();
    @(negedge clk);
    while (fetch_rvalid_o) @(negedge clk);
  endtask

  // one fetch, held until the cache answers
  task automatic fetch_one(input int idx);
    logic [31:0] data;
    @(posedge clk);
    #1;
    cur_addr = addr_q[idx];
    fetch_valid_i = 1'b1;
    fetch_addr_i = addr_q[idx];
    @(negedge clk);
    while (!fetch_rvalid_o) @(negedge clk);
    data = fetch_rdata_o;
    @(posedge clk);
    #1;
    fetch_valid_i = 1'b0;
    drain_responses();
    check_value({name_q[idx], " data"}, word_q[idx], data);
    check_value({name_q[idx], " requests"}, count_q[idx], req_count);
  endtask

  // new address every cycle, each answer one cycle after its address
  task automatic fetch_stream(input int first, input int stop);
    @(posedge clk);
    #1;
    cur_addr = addr_q[first];
    fetch_valid_i = 1'b1;
    fetch_addr_i = addr_q[first];
    for (int k = first; k < stop; k++) begin
      @(posedge clk);
      #1;
      if (k + 1 < stop) begin
        cur_addr = addr_q[k + 1];
        fetch_addr_i = addr_q[k + 1];
      end else begin
        fetch_valid_i = 1'b0;
      end
      @(negedge clk);
      if (fetch_rvalid_o) begin
        check_value({name_q[k], " data"}, word_q[k], fetch_rdata_o);
      end else begin
        $display("%s: no answer in the cycle after fetch of %h", name_q[k], addr_q[k]);
        protocol_errors++;
      end
      check_value({name_q[k], " requests"}, count_q[k], req_count);
    end
    drain_responses();
  endtask

  task automatic finish_run();
    $display("errors: %0d mismatch, %0d protocol, %0d timeout",
             mismatch_errors, protocol_errors, timeout_errors);
    if (mismatch_errors + protocol_errors + timeout_errors == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  endtask

  // memory model with random gaps before each beat
  initial begin
    mem_req_t req;
    int gap;
    void'($urandom(32'hdc97));
    mem_rvalid_i = 1'b0;
    mem_rdata_i = '0;
    forever begin
      @(negedge clk);
      if (mem_req_valid_o) begin
        req = mem_req_o;
        req_count++;
        check_request(req);
        for (int k = 0; k <= int'(req.len); k++) begin
          gap = int'($urandom % 4);
          repeat (gap) begin
            @(posedge clk);
            #1;
            mem_rvalid_i = 1'b0;
          end
          @(posedge clk);
          #1;
          if (!mem_req_valid_o || mem_req_o != req) begin
            $display("memory request changed or dropped before beat %0d", k);
            protocol_errors++;
          end
          mem_rvalid_i = 1'b1;
          mem_rdata_i = mem_word(req.addr + 32'(k) * 32'd4);
        end
        @(posedge clk);
        #1;
        mem_rvalid_i = 1'b0;
      end
    end
  end

  // watchdog, worst case of a full slow refill per stimulus line
  initial begin
    wait (loaded);
    #(longint'(name_q.size()) * 16 * 4 * 20 + 2000);
    $display("timeout: the fetch sequence did not finish in time");
    timeout_errors++;
    finish_run();
  end

  initial begin
    int i;
    int j;
    rst = 1'b1;
    fetch_valid_i = 1'b0;
    fetch_addr_i = '0;
    cur_addr = '0;
    load_stimulus();
    repeat (5) @(posedge clk);
    #1;
    rst = 1'b0;
    // quiet outputs with no fetch pending
    repeat (4) begin
      @(negedge clk);
      if (fetch_rvalid_o || mem_req_valid_o) begin
        $display("fetch or memory valid is high after reset with no fetch pending");
        protocol_errors++;
      end
    end
    i = 0;
    while (i < name_q.size()) begin
      if (name_q[i] == "hit_burst") begin
        // group consecutive burst lines into one stream
        j = i;
        while (j < name_q.size() && name_q[j] == "hit_burst") j++;
        fetch_stream(i, j);
        i = j;
      end else begin
        fetch_one(i);
        i++;
      end
    end
    finish_run();
  end

endmodule

// ==== hw/icache_ctrl.sv ====
`timescale 1ns/1ps

module icache_ctrl import icache_pkg::*, mem_bus_pkg::*; (
  input  logic                  clk,
  input  logic                  rst,
  // fetch side
  input  logic                  fetch_valid_i,
  input  logic [ADDR_W-1:0]     fetch_addr_i,
  output logic                  fetch_rvalid_o,
  output logic [DATA_W-1:0]     fetch_rdata_o,
  // memory side
  output logic                  mem_req_valid_o,
  output mem_req_t              mem_req_o,
  input  logic                  mem_rvalid_i,
  input  logic [DATA_W-1:0]     mem_rdata_i,
  // to tag and data arrays
  output fetch_addr_t           req_addr_o,
  input  logic                  hit_i,
  output logic                  alloc_o,
  output logic                  line_wen_o,
  output logic [WORD_SEL_W-1:0] line_wsel_o,
  output logic [DATA_W-1:0]     line_wdata_o,
  input  logic [DATA_W-1:0]     line_rdata_i
);

  icache_state_e state_q;
  fetch_addr_t req_addr_q;
  word_sel_t beat_cnt_q;
  logic unc_done_q;
  logic [DATA_W-1:0] unc_data_q;
  logic mem_req_valid_q;
  mem_req_t mem_req_q;

  logic uncached;
  logic lookup_hit;
  logic lookup_miss;
  logic beat;
  logic last_beat;
  logic capture;

  // uncached region from the top address bits
  assign uncached = req_addr_q.tag[TAG_W-1 -: REGION_W] == UNCACHED_REGION_MSB;

  // uncached addresses never count as hits
  assign lookup_hit = (state_q == LOOKUP) && hit_i && !uncached;
  assign lookup_miss = (state_q == LOOKUP) && !lookup_hit;

  // a beat is any cycle with request and data both high
  assign beat = mem_req_valid_q && mem_rvalid_i;
  assign last_beat = beat && (beat_cnt_q == mem_req_q.len[WORD_SEL_W-1:0]);

  // take a new address when idle or on the cycle a hit returns
  assign capture = fetch_valid_i && ((state_q == IDLE) || lookup_hit);

  // state, beat counter and request valid
  always_ff @(posedge clk) begin
    if (rst) begin
      state_q <= IDLE;
      beat_cnt_q <= '0;
      unc_done_q <= 1'b0;
      mem_req_valid_q <= 1'b0;
    end else begin
      case (state_q)
        IDLE: begin
          if (fetch_valid_i) begin
            state_q <= LOOKUP;
          end
        end
        LOOKUP: begin
          if (uncached) begin
            state_q <= UNCACHED;
            mem_req_valid_q <= 1'b1;
          end else if (!hit_i) begin
            state_q <= REFILL;
            mem_req_valid_q <= 1'b1;
            beat_cnt_q <= '0;
          end else if (!fetch_valid_i) begin
            // hit and nothing new pending
            state_q <= IDLE;
          end
        end
        REFILL: begin
          if (last_beat) begin
            // line complete, retry the held address
            state_q <= LOOKUP;
            mem_req_valid_q <= 1'b0;
          end else if (beat) begin
            beat_cnt_q <= beat_cnt_q + WORD_SEL_W'(1);
          end
        end
        UNCACHED: begin
          if (unc_done_q) begin
            // word was returned this cycle
            state_q <= IDLE;
            unc_done_q <= 1'b0;
          end else if (beat) begin
            mem_req_valid_q <= 1'b0;
            unc_done_q <= 1'b1;
          end
        end
        default: begin
          state_q <= IDLE;
        end
      endcase
    end
  end

  // address, request payload and uncached word
  always_ff @(posedge clk) begin
    if (capture) begin
      req_addr_q <= fetch_addr_i;
    end
    if (lookup_miss) begin
      mem_req_q.size <= SIZE_WORD;
      if (uncached) begin
        // single word, no allocation
        mem_req_q.addr <= {req_addr_q.tag, req_addr_q.index, req_addr_q.word, 2'b00};
        mem_req_q.len <= BURST_LEN_SINGLE;
      end else begin
        // whole line from offset zero
        mem_req_q.addr <= {req_addr_q.tag, req_addr_q.index, {OFFSET_W{1'b0}}};
        mem_req_q.len <= BURST_LEN_LINE;
      end
    end
    if ((state_q == UNCACHED) && beat) begin
      unc_data_q <= mem_rdata_i;
    end
  end

  // fetch return
  assign fetch_rvalid_o = lookup_hit || unc_done_q;
  assign fetch_rdata_o = (state_q == UNCACHED) ? unc_data_q : line_rdata_i;

  // memory request held until the last beat
  assign mem_req_valid_o = mem_req_valid_q;
  assign mem_req_o = mem_req_q;

  // refill beats go straight into the data array
  assign req_addr_o = req_addr_q;
  assign line_wen_o = (state_q == REFILL) && beat;
  assign line_wsel_o = beat_cnt_q;
  assign line_wdata_o = mem_rdata_i;
  // tag written with the final beat
  assign alloc_o = (state_q == REFILL) && last_beat;

endmodule

// ==== hw/icache_data.sv ====
`timescale 1ns/1ps

module icache_data import icache_pkg::*; (
  input  logic                  clk,
  // index and word select come from the registered address
  input  fetch_addr_t           addr_i,
  // one refill beat
  input  logic                  wen_i,
  input  logic [WORD_SEL_W-1:0] wsel_i,
  input  logic [DATA_W-1:0]     wdata_i,
  // word at addr_i
  output logic [DATA_W-1:0]     rdata_o
);

  // 128 lines of 16 words
  logic [DATA_W-1:0] line_q [NUM_LINES][WORDS_PER_LINE];

  index_t rd_index;
  word_sel_t rd_word;

  assign rd_index = addr_i.index;
  assign rd_word = addr_i.word;

  // beat write
  // the write index stays on the missed line during the burst
  // and the word comes from the beat counter, not from addr_i
  always_ff @(posedge clk) begin
    if (wen_i) begin
      line_q[addr_i.index][wsel_i] <= wdata_i;
    end
  end

  // combinational word read
  // only meaningful once the tag array reports a hit
  assign rdata_o = line_q[rd_index][rd_word];

endmodule

// ==== hw/icache_pkg.sv ====
package icache_pkg;

  // fetch side bus widths
  localparam int ADDR_W = 32;
  localparam int DATA_W = 32;

  // 8 KB direct mapped, 64-byte lines
  localparam int OFFSET_W = 6;
  localparam int INDEX_W = 7;
  localparam int TAG_W = ADDR_W - INDEX_W - OFFSET_W;
  localparam int NUM_LINES = 1 << INDEX_W;

  // 32-bit words inside one line
  localparam int WORD_SEL_W = 4;
  localparam int WORDS_PER_LINE = 1 << WORD_SEL_W;

  typedef logic [TAG_W-1:0] tag_t;
  typedef logic [INDEX_W-1:0] index_t;
  typedef logic [WORD_SEL_W-1:0] word_sel_t;

  // fetch address split into its cache fields, msb first
  typedef struct packed {
    tag_t tag;
    index_t index;
    word_sel_t word;
    // byte within the word, zero for aligned fetches
    logic [OFFSET_W-WORD_SEL_W-1:0] byte_off;
  } fetch_addr_t;

  // controller states
  typedef enum logic [1:0] {
    IDLE,
    LOOKUP,
    REFILL,
    UNCACHED
  } icache_state_e;

endpackage

// ==== hw/icache_tag.sv ====
`timescale 1ns/1ps

module icache_tag import icache_pkg::*; (
  input  logic        clk,
  input  logic        rst,
  // registered request address from the controller
  input  fetch_addr_t addr_i,
  // write tag and set valid for the line at addr_i
  input  logic        alloc_i,
  output logic        hit_o
);

  // one tag per line
  tag_t tag_q [NUM_LINES];
  // valid bits cleared by reset
  logic [NUM_LINES-1:0] valid_q;

  tag_t stored_tag;
  logic stored_valid;

  // read the entry selected by the index
  assign stored_tag = tag_q[addr_i.index];
  assign stored_valid = valid_q[addr_i.index];

  // same-cycle compare
  assign hit_o = stored_valid && (stored_tag == addr_i.tag);

  // valid bits
  always_ff @(posedge clk) begin
    if (rst) begin
      valid_q <= '0;
    end else if (alloc_i) begin
      valid_q[addr_i.index] <= 1'b1;
    end
  end

  // tag storage
  // an alloc overwrites whatever line sat at this index
  always_ff @(posedge clk) begin
    if (alloc_i) begin
      tag_q[addr_i.index] <= addr_i.tag;
    end
  end

endmodule

// ==== hw/icache_top.sv ====
`timescale 1ns/1ps

module icache_top import icache_pkg::*, mem_bus_pkg::*; (
  input  logic              clk,
  input  logic              rst,
  // fetch unit
  input  logic              fetch_valid_i,
  input  logic [ADDR_W-1:0] fetch_addr_i,
  output logic              fetch_rvalid_o,
  output logic [DATA_W-1:0] fetch_rdata_o,
  // memory
  output logic              mem_req_valid_o,
  output mem_req_t          mem_req_o,
  input  logic              mem_rvalid_i,
  input  logic [DATA_W-1:0] mem_rdata_i
);

  // controller to arrays
  fetch_addr_t req_addr;
  logic hit;
  logic alloc;
  logic line_wen;
  logic [WORD_SEL_W-1:0] line_wsel;
  logic [DATA_W-1:0] line_wdata;
  logic [DATA_W-1:0] line_rdata;

  icache_ctrl u_icache_ctrl (
    .clk             (clk),
    .rst             (rst),
    .fetch_valid_i   (fetch_valid_i),
    .fetch_addr_i    (fetch_addr_i),
    .fetch_rvalid_o  (fetch_rvalid_o),
    .fetch_rdata_o   (fetch_rdata_o),
    .mem_req_valid_o (mem_req_valid_o),
    .mem_req_o       (mem_req_o),
    .mem_rvalid_i    (mem_rvalid_i),
    .mem_rdata_i     (mem_rdata_i),
    .req_addr_o      (req_addr),
    .hit_i           (hit),
    .alloc_o         (alloc),
    .line_wen_o      (line_wen),
    .line_wsel_o     (line_wsel),
    .line_wdata_o    (line_wdata),
    .line_rdata_i    (line_rdata)
  );

  // tag and valid state
  icache_tag u_icache_tag (
    .clk     (clk),
    .rst     (rst),
    .addr_i  (req_addr),
    .alloc_i (alloc),
    .hit_o   (hit)
  );

  // line storage
  icache_data u_icache_data (
    .clk     (clk),
    .addr_i  (req_addr),
    .wen_i   (line_wen),
    .wsel_i  (line_wsel),
    .wdata_i (line_wdata),
    .rdata_o (line_rdata)
  );

endmodule

// ==== hw/mem_bus_pkg.sv ====
package mem_bus_pkg;

  // memory side request fields
  localparam int MEM_ADDR_W = 32;
  localparam int MEM_LEN_W = 8;
  localparam int MEM_SIZE_W = 4;

  // burst length is beats minus one
  localparam logic [MEM_LEN_W-1:0] BURST_LEN_LINE = 8'd15;
  localparam logic [MEM_LEN_W-1:0] BURST_LEN_SINGLE = 8'd0;
  // 4-byte beats
  localparam logic [MEM_SIZE_W-1:0] SIZE_WORD = 4'b0100;

  // uncached region, decoded from address bits [31:28]
  localparam int REGION_W = 4;
  localparam logic [REGION_W-1:0] UNCACHED_REGION_MSB = 4'h1;

  typedef struct packed {
    logic [MEM_ADDR_W-1:0] addr;
    logic [MEM_LEN_W-1:0] len;
    logic [MEM_SIZE_W-1:0] size;
  } mem_req_t;

endpackage

// ==== icache.f ====
hw/icache_pkg.sv
hw/mem_bus_pkg.sv
hw/icache_tag.sv
hw/icache_data.sv
hw/icache_ctrl.sv
hw/icache_top.sv
dv/icache_tb.sv
